/* design/arkctl_pkg.sv */
// Scan codes, event and control structs, quadrature step helper and shared constants
package arkctl_pkg;

	////////////////////////////////////////////////////////////
	// Keyboard scan codes (set 2 make codes)
	localparam logic [7:0] KEY_START1  = 8'h16; // 1
	localparam logic [7:0] KEY_START2  = 8'h1E; // 2
	localparam logic [7:0] KEY_COIN1   = 8'h2E; // 5
	localparam logic [7:0] KEY_COIN2   = 8'h36; // 6
	localparam logic [7:0] KEY_SERVICE = 8'h46; // 9
	localparam logic [7:0] KEY_FAST    = 8'h11; // Alt
	localparam logic [7:0] KEY_LEFT    = 8'h6B; // Cursor left
	localparam logic [7:0] KEY_RIGHT   = 8'h74; // Cursor right
	localparam logic [7:0] KEY_FIRE    = 8'h29; // Space

	// Position accumulator width and d-pad burst sizes
	localparam int POS_W = 12;
	localparam logic [POS_W-1:0] DPAD_SLOW = 12'd4;
	localparam logic [POS_W-1:0] DPAD_FAST = 12'd9;

	localparam logic [7:0] DIP_INDEX = 8'd254; // Loader slot of the DIP byte
	localparam logic [1:0] QUAD_IDLE = 2'b11;  // Spinner code out of reset

	////////////////////////////////////////////////////////////
	// Event and control bundles
	typedef struct packed {
		logic       toggle;  // Flips once per new event
		logic       pressed; // 1 make, 0 break
		logic [7:0] code;
	} key_evt_t;

	typedef struct packed {
		logic       toggle;    // Flips once per report
		logic       btn_left;
		logic       btn_right;
		logic       x_sign;    // Sign of the X motion
		logic [7:0] dx;        // Low byte of X motion, two's complement
	} mouse_evt_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin1;
		logic coin2;
		logic service;
		logic fast;
		logic left;
		logic right;
		logic fire;
	} kbd_btn_t;

	// All active high, the game side inverts as needed
	typedef struct packed {
		logic coin1;
		logic coin2;
		logic fire;
		logic service;
		logic start1;
		logic start2;
	} cab_ctrl_t;

	////////////////////////////////////////////////////////////
	// One quadrature step, dir 1 walks 00 01 11 10
	function automatic logic [1:0] quad_next(input logic dir, input logic [1:0] code);
		logic [1:0] nxt;
		case ({dir, code})
			3'b1_00: nxt = 2'b01;
			3'b1_01: nxt = 2'b11;
			3'b1_11: nxt = 2'b10;
			3'b1_10: nxt = 2'b00;
			3'b0_00: nxt = 2'b10; // Reverse walk
			3'b0_10: nxt = 2'b11;
			3'b0_11: nxt = 2'b01;
			default: nxt = 2'b00; // 3'b0_01
		endcase
		return nxt;
	endfunction

endpackage

/* design/cabinet_inputs.sv */
// Cabinet control merge, DIP byte register and spinner source select
module cabinet_inputs (
	input  logic                  CLK_12M,
	input  logic                  rst_n,
	input  arkctl_pkg::kbd_btn_t  btn,
	input  logic [7:0]            joy,        // Active high pad buttons
	input  logic [1:0]            mouse_btn,
	input  logic                  fire_pin_n, // Cabinet fire switch, low when pressed
	input  logic [1:0]            emu_code,
	input  logic                  emu_active,
	input  logic [1:0]            raw_code,
	input  logic                  enc_moved,
	input  logic                  ld_wr,
	input  logic [7:0]            ld_index,
	input  logic [7:0]            ld_addr,
	input  logic [7:0]            ld_data,
	output arkctl_pkg::cab_ctrl_t ctrl,
	output logic [1:0]            spinner,
	output logic [7:0]            dip
);

	logic [7:0] dip_q;  // Stored active low, like the switch bank
	logic       use_raw; // Physical encoder owns the spinner
	logic       dip_wr;

	assign dip_wr  = ld_wr && (ld_index == arkctl_pkg::DIP_INDEX) && (ld_addr == 8'd0);
	assign dip     = ~dip_q;
	assign spinner = use_raw ? raw_code : emu_code;

	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			ctrl    <= '0;
			dip_q   <= 8'hFF; // All switches off
			use_raw <= 1'b0;
		end else begin
			ctrl.fire    <= btn.fire | joy[4] | (|mouse_btn) | ~fire_pin_n;
			ctrl.start1  <= btn.start1 | joy[6];
			ctrl.coin1   <= btn.coin1 | joy[7];
			ctrl.start2  <= btn.start2; // Pad has no ninth button
			ctrl.coin2   <= btn.coin2;
			ctrl.service <= btn.service;
			if (dip_wr)
				dip_q <= ld_data;
			if (enc_moved)
				use_raw <= 1'b1; // Encoder motion takes over
			else if (emu_active)
				use_raw <= 1'b0;
		end
	end

endmodule

/* design/control_top.sv */
// Control front end top: key decoder, spinner emulator, encoder path and input merge
module control_top #(
	parameter int STEP_DIV   = 1500,  // About 4 kHz step rate at 6 MHz tick
	parameter int POLL_TICKS = 48000  // About 8 ms, a mouse poll period
) (
	input  logic                   CLK_12M,
	input  logic                   rst_n,
	input  arkctl_pkg::key_evt_t   key,
	input  arkctl_pkg::mouse_evt_t mouse,
	input  logic [7:0]             joy,
	input  logic [3:0]             user_in,  // [1:0] encoder A/B, [3] fire low
	input  logic                   ld_wr,
	input  logic [7:0]             ld_index,
	input  logic [7:0]             ld_addr,
	input  logic [7:0]             ld_data,
	output arkctl_pkg::cab_ctrl_t  ctrl,
	output logic [1:0]             spinner,
	output logic [7:0]             dip
);

	arkctl_pkg::kbd_btn_t kbd_btn;
	logic                 dpad_left;
	logic                 dpad_right;
	logic                 dpad_fast;
	logic [1:0]           emu_code;
	logic                 emu_active;
	logic [1:0]           raw_code;
	logic                 enc_moved;

	////////////////////////////////////////////////////////////
	// Keyboard
	key_decoder u_key_decoder (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n),
		.key     (key),
		.btn     (kbd_btn)
	);

	// D-pad levels feed the emulator directly
	assign dpad_left  = kbd_btn.left | joy[1];
	assign dpad_right = kbd_btn.right | joy[0];
	assign dpad_fast  = kbd_btn.fast | joy[5];

	////////////////////////////////////////////////////////////
	// Position sources
	spinner_emu #(
		.STEP_DIV   (STEP_DIV),
		.POLL_TICKS (POLL_TICKS)
	) u_spinner_emu (
		.CLK_12M    (CLK_12M),
		.rst_n      (rst_n),
		.mouse      (mouse),
		.left       (dpad_left),
		.right      (dpad_right),
		.fast       (dpad_fast),
		.emu_code   (emu_code),
		.emu_active (emu_active)
	);

	quad_encoder_halver u_quad_encoder_halver (
		.CLK_12M   (CLK_12M),
		.rst_n     (rst_n),
		.enc       (user_in[1:0]),
		.raw_code  (raw_code),
		.enc_moved (enc_moved)
	);

	////////////////////////////////////////////////////////////
	// Merge to the cabinet side
	cabinet_inputs u_cabinet_inputs (
		.CLK_12M    (CLK_12M),
		.rst_n      (rst_n),
		.btn        (kbd_btn),
		.joy        (joy),
		.mouse_btn  ({mouse.btn_left, mouse.btn_right}),
		.fire_pin_n (user_in[3]),
		.emu_code   (emu_code),
		.emu_active (emu_active),
		.raw_code   (raw_code),
		.enc_moved  (enc_moved),
		.ld_wr      (ld_wr),
		.ld_index   (ld_index),
		.ld_addr    (ld_addr),
		.ld_data    (ld_data),
		.ctrl       (ctrl),
		.spinner    (spinner),
		.dip        (dip)
	);

endmodule

/* design/key_decoder.sv */
// Keyboard event decoder producing held button levels
module key_decoder (
	input  logic                 CLK_12M,
	input  logic                 rst_n,
	input  arkctl_pkg::key_evt_t key,
	output arkctl_pkg::kbd_btn_t btn
);

	logic tgl_q;   // Toggle bit seen last cycle
	logic new_evt; // Toggle moved, one fresh key event

	assign new_evt = key.toggle != tgl_q;

	////////////////////////////////////////////////////////////
	// Make sets the button, break clears it
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			tgl_q <= key.toggle; // Stale event in flight is not replayed
			btn   <= '0;
		end else begin
			tgl_q <= key.toggle;
			if (new_evt) begin
				case (key.code)
					arkctl_pkg::KEY_START1:  btn.start1  <= key.pressed;
					arkctl_pkg::KEY_START2:  btn.start2  <= key.pressed;
					arkctl_pkg::KEY_COIN1:   btn.coin1   <= key.pressed;
					arkctl_pkg::KEY_COIN2:   btn.coin2   <= key.pressed;
					arkctl_pkg::KEY_SERVICE: btn.service <= key.pressed;
					arkctl_pkg::KEY_FAST:    btn.fast    <= key.pressed;
					arkctl_pkg::KEY_LEFT:    btn.left    <= key.pressed;
					arkctl_pkg::KEY_RIGHT:   btn.right   <= key.pressed;
					arkctl_pkg::KEY_FIRE:    btn.fire    <= key.pressed;
					default: ; // Other keys belong to nobody here
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Levels only move right behind an event on the key port
	a_btn_after_evt: assert property (
		@(posedge CLK_12M) disable iff (!rst_n)
		(btn != $past(btn)) |-> $past(key.toggle != tgl_q)
	) else $error("key_decoder: button moved without a key event");

endmodule

/* design/quad_encoder_halver.sv */
// Physical A/B encoder re-encoder stepping on A-phase edges only
module quad_encoder_halver (
	input  logic       CLK_12M,
	input  logic       rst_n,
	input  logic [1:0] enc,       // [0] A pin, [1] B pin
	output logic [1:0] raw_code,
	output logic       enc_moved  // Either pin changed
);

	logic [1:0] enc_q; // Sampling stage
	logic [1:0] enc_d; // Previous sample for edge detect
	logic       a_edge;
	logic       dir;

	assign a_edge    = enc_q[0] != enc_d[0];
	assign dir       = enc_q[0] ^ enc_q[1]; // Phase relation gives the turn direction
	assign enc_moved = enc_q != enc_d;

	////////////////////////////////////////////////////////////
	// Half resolution, B edges never step the code
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			enc_q    <= enc;  // No phantom edge when reset drops
			enc_d    <= enc;
			raw_code <= arkctl_pkg::QUAD_IDLE;
		end else begin
			enc_q <= enc;
			enc_d <= enc_q;
			if (a_edge)
				raw_code <= arkctl_pkg::quad_next(dir, raw_code);
		end
	end

	// Pin A must have toggled two clocks before any step
	a_step_after_a_edge: assert property (
		@(posedge CLK_12M) disable iff (!rst_n)
		(raw_code != $past(raw_code)) |-> ($past(enc[0], 2) != $past(enc[0], 3))
	) else $error("quad_encoder_halver: step without an A edge");

endmodule

/* design/spinner_emu.sv */
// Spinner emulator: position accumulator, step divider and d-pad poll timer
module spinner_emu #(
	parameter int STEP_DIV   = 1500,  // Ticks per quadrature step
	parameter int POLL_TICKS = 48000  // Ticks between d-pad reloads
) (
	input  logic                   CLK_12M,
	input  logic                   rst_n,
	input  arkctl_pkg::mouse_evt_t mouse,
	input  logic                   left,       // D-pad left held
	input  logic                   right,      // D-pad right held
	input  logic                   fast,       // Larger d-pad bursts
	output logic [1:0]             emu_code,
	output logic                   emu_active  // One clock per active tick
);

	localparam int POS_W  = arkctl_pkg::POS_W;
	localparam int DIV_W  = (STEP_DIV > 1) ? $clog2(STEP_DIV) : 1;
	localparam int POLL_W = (POLL_TICKS > 1) ? $clog2(POLL_TICKS) : 1;

	logic              tick;        // High every other clock
	logic [DIV_W-1:0]  div_cnt;
	logic [POLL_W-1:0] poll_cnt;
	logic [POS_W-1:0]  pos;         // Signed steps still owed
	logic              mouse_tgl_q;

	logic              mouse_evt;
	logic              dpad_held;
	logic              div_wrap;
	logic              poll_wrap;
	logic              pos_busy;    // Steps still to play out
	logic              near_sat;
	logic [POS_W-1:0]  dx_ext;
	logic [POS_W-1:0]  dpad_mag;
	logic [POS_W-1:0]  dpad_load;
	logic [POS_W-1:0]  pos_step;
	logic [POS_W-1:0]  pos_nxt;

	////////////////////////////////////////////////////////////
	// Event detect and timer wraps
	assign mouse_evt = mouse.toggle != mouse_tgl_q;
	assign dpad_held = left | right;
	assign div_wrap  = div_cnt == DIV_W'(STEP_DIV - 1);
	assign poll_wrap = poll_cnt == POLL_W'(POLL_TICKS - 1);
	assign pos_busy  = pos != '0;
	assign near_sat  = pos[POS_W-1] != pos[POS_W-2]; // Top two bits disagree

	assign dx_ext    = {{(POS_W-8){mouse.x_sign}}, mouse.dx};
	assign dpad_mag  = fast ? arkctl_pkg::DPAD_FAST : arkctl_pkg::DPAD_SLOW;
	assign dpad_load = right ? dpad_mag : -dpad_mag; // Right wins if both held

	// Source priority: step, then mouse add, then d-pad reload on top
	always_comb begin
		pos_step = pos;
		if (pos_busy && div_wrap) begin
			if (pos[POS_W-1])
				pos_step = pos + POS_W'(1); // Walk back up to zero
			else
				pos_step = pos - POS_W'(1);
		end
		pos_nxt = pos_step;
		if (mouse_evt && !near_sat)
			pos_nxt = pos_step + dx_ext; // Keeps the step already taken
		if (dpad_held && poll_wrap)
			pos_nxt = dpad_load;
	end

	////////////////////////////////////////////////////////////
	// Tick domain state
	always_ff @(posedge CLK_12M) begin
		if (!rst_n) begin
			tick        <= 1'b0;
			div_cnt     <= '0;
			poll_cnt    <= '0;
			pos         <= '0;
			mouse_tgl_q <= mouse.toggle;
			emu_code    <= arkctl_pkg::QUAD_IDLE;
			emu_active  <= 1'b0;
		end else begin
			tick       <= ~tick;
			emu_active <= 1'b0;
			if (tick) begin
				mouse_tgl_q <= mouse.toggle; // Sampled on ticks only
				div_cnt     <= div_wrap ? '0 : div_cnt + DIV_W'(1);

				// Poll timer runs only while the d-pad is held
				if (dpad_held)
					poll_cnt <= poll_wrap ? '0 : poll_cnt + POLL_W'(1);
				else
					poll_cnt <= '0;

				// Negative position plays the forward walk
				if (pos_busy && div_wrap)
					emu_code <= arkctl_pkg::quad_next(pos[POS_W-1], emu_code);

				pos        <= pos_nxt;
				emu_active <= mouse_evt | dpad_held;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Code is Gray stepped and only while steps are owed
	a_code_one_bit: assert property (
		@(posedge CLK_12M) disable iff (!rst_n)
		(emu_code != $past(emu_code)) |-> $onehot(emu_code ^ $past(emu_code))
	) else $error("spinner_emu: code jumped by more than one bit");

	a_code_needs_pos: assert property (
		@(posedge CLK_12M) disable iff (!rst_n)
		(emu_code != $past(emu_code)) |-> ($past(pos) != '0)
	) else $error("spinner_emu: code moved with zero position");

endmodule

/* dv/tb_control_top.sv */
// Testbench for control_top with clock, reset, stimulus tasks, reference models and assertions
module tb_control_top;

	localparam int STEP_DIV   = 4;   // Clocks per step is twice this
	localparam int POLL_TICKS = 24;
	localparam int N_BURSTS   = 12;  // Random mouse events
	localparam int IDLE_WIN   = 3 * 2 * STEP_DIV + 4; // Quiet window that ends a burst
	localparam int BURST_CYC  = 100 * 2 * STEP_DIV + 64; // Longest mouse burst
	localparam int MAX_CYCLES = (N_BURSTS + 1) * BURST_CYC + 4 * 4 * 2 * POLL_TICKS + 6000;

	logic                   CLK_12M;
	logic                   rst_n;
	arkctl_pkg::key_evt_t   key;
	arkctl_pkg::mouse_evt_t mouse;
	logic [7:0]             joy;
	logic [3:0]             user_in;
	logic                   ld_wr;
	logic [7:0]             ld_index;
	logic [7:0]             ld_addr;
	logic [7:0]             ld_data;
	arkctl_pkg::cab_ctrl_t  ctrl;
	logic [1:0]             spinner;
	logic [7:0]             dip;

	arkctl_pkg::cab_ctrl_t  kb_lvl;     // Keyboard part of ctrl as of the key event
	arkctl_pkg::cab_ctrl_t  direct_lvl; // Pad, mouse and pin part of ctrl
	logic [7:0]             dip_ref;
	logic [1:0]             raw_ref;    // Expected encoder code
	logic                   enc_own;    // Encoder should drive the spinner
	logic                   chk_en;
	logic                   track_en;   // Count spinner steps
	logic                   burst_chk;  // One cycle strobe at the end of a burst
	logic [1:0]             spin_prev;
	logic [31:0]            lcg_state;
	int                     fwd_cnt;
	int                     rev_cnt;
	int                     exp_fwd;
	int                     exp_rev;
	int                     errors;
	int                     bursts;
	int                     cycles;

	control_top #(
		.STEP_DIV   (STEP_DIV),
		.POLL_TICKS (POLL_TICKS)
	) u_control_top (
		.CLK_12M  (CLK_12M),
		.rst_n    (rst_n),
		.key      (key),
		.mouse    (mouse),
		.joy      (joy),
		.user_in  (user_in),
		.ld_wr    (ld_wr),
		.ld_index (ld_index),
		.ld_addr  (ld_addr),
		.ld_data  (ld_data),
		.ctrl     (ctrl),
		.spinner  (spinner),
		.dip      (dip)
	);

	always #20 CLK_12M = ~CLK_12M;

	////////////////////////////////////////////////////////////
	// Reference helpers
	// Quadrature walk through the Gray phase index where fwd is 00 01 11 10
	function automatic logic [1:0] quad_step(input logic fwd, input logic [1:0] c);
		logic [1:0] ph;
		ph = {c[1], c[1] ^ c[0]};            // Gray to phase
		ph = fwd ? ph + 2'd1 : ph - 2'd1;
		return {ph[1], ph[1] ^ ph[0]};       // Phase back to Gray
	endfunction

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	always_comb begin
		direct_lvl        = '0;
		direct_lvl.fire   = joy[4] | mouse.btn_left | mouse.btn_right | ~user_in[3];
		direct_lvl.start1 = joy[6];
		direct_lvl.coin1  = joy[7];
	end

	// Step counter on the spinner output that resyncs while tracking is off
	always @(posedge CLK_12M) begin
		if (track_en && spinner != spin_prev) begin
			if (spinner == quad_step(1'b1, spin_prev))
				fwd_cnt <= fwd_cnt + 1;
			else if (spinner == quad_step(1'b0, spin_prev))
				rev_cnt <= rev_cnt + 1;
		end
		spin_prev <= spinner;
	end

	// Run length guard
	always @(posedge CLK_12M) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: test sequence did not finish within %0d cycles", MAX_CYCLES);
			$display("Errors: %0d, bursts checked: %0d", errors, bursts);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	a_reset_state: assert property (@(posedge CLK_12M)
		$rose(rst_n) |-> (ctrl == '0 && spinner == 2'b11 && dip == 8'h00)
	) else begin
		errors = errors + 1;
		$display("ERR %0t: state after reset ctrl=%b spinner=%b dip=%h",
			$time, ctrl, spinner, dip);
	end

	// Keys land two cycles late and direct buttons one
	a_ctrl_merge: assert property (@(posedge CLK_12M)
		chk_en |-> (ctrl == ($past(kb_lvl, 2) | $past(direct_lvl)))
	) else begin
		errors = errors + 1;
		$display("ERR %0t: ctrl=%b does not match the button sources", $time, ctrl);
	end

	a_dip_value: assert property (@(posedge CLK_12M)
		chk_en |-> (dip == $past(dip_ref))
	) else begin
		errors = errors + 1;
		$display("ERR %0t: dip=%h expected %h", $time, dip, $past(dip_ref));
	end

	a_step_legal: assert property (@(posedge CLK_12M)
		(track_en && $past(track_en) && spinner != $past(spinner)) |->
		(spinner == quad_step(1'b1, $past(spinner)) ||
			spinner == quad_step(1'b0, $past(spinner)))
	) else begin
		errors = errors + 1;
		$display("ERR %0t: spinner jumped %b to %b", $time, $past(spinner), spinner);
	end

	a_burst_count: assert property (@(posedge CLK_12M)
		burst_chk |-> (fwd_cnt == exp_fwd && rev_cnt == exp_rev)
	) else begin
		errors = errors + 1;
		$display("ERR %0t: steps fwd %0d rev %0d, expected %0d %0d",
			$time, fwd_cnt, rev_cnt, exp_fwd, exp_rev);
	end

	// Encoder path is two registers deep
	a_encoder_code: assert property (@(posedge CLK_12M)
		(enc_own && $past(enc_own, 2)) |-> (spinner == $past(raw_ref, 2))
	) else begin
		errors = errors + 1;
		$display("ERR %0t: spinner=%b expected encoder code %b",
			$time, spinner, $past(raw_ref, 2));
	end

	////////////////////////////////////////////////////////////
	// Stimulus tasks
	task automatic next_cycle();
		@(posedge CLK_12M);
		#5;
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		key.toggle  = ~key.toggle;
		key.pressed = pressed;
		key.code    = code;
		case (code)
			arkctl_pkg::KEY_START1:  kb_lvl.start1  = pressed;
			arkctl_pkg::KEY_START2:  kb_lvl.start2  = pressed;
			arkctl_pkg::KEY_COIN1:   kb_lvl.coin1   = pressed;
			arkctl_pkg::KEY_COIN2:   kb_lvl.coin2   = pressed;
			arkctl_pkg::KEY_SERVICE: kb_lvl.service = pressed;
			arkctl_pkg::KEY_FIRE:    kb_lvl.fire    = pressed;
			default: ; // Not a cabinet control
		endcase
	endtask

	task automatic dip_write(input logic [7:0] index, input logic [7:0] addr,
			input logic [7:0] data);
		ld_wr    = 1'b1;
		ld_index = index;
		ld_addr  = addr;
		ld_data  = data;
		if (index == 8'd254 && addr == 8'd0)
			dip_ref = ~data; // Stored byte is active low
		next_cycle();
		ld_wr = 1'b0;
	endtask

	task automatic end_burst();
		repeat (IDLE_WIN) next_cycle();
		burst_chk = 1'b1;
		next_cycle();
		burst_chk = 1'b0;
		bursts    = bursts + 1;
	endtask

	// Positive dx plays the reverse walk
	task automatic mouse_burst(input int dx);
		int mag;
		int base;
		int guard;
		mag      = (dx < 0) ? -dx : dx;
		exp_fwd  = fwd_cnt + ((dx < 0) ? mag : 0);
		exp_rev  = rev_cnt + ((dx > 0) ? mag : 0);
		track_en = 1'b0; // Source may switch back here
		mouse.toggle = ~mouse.toggle;
		mouse.x_sign = (dx < 0);
		mouse.dx     = dx[7:0];
		repeat (4) next_cycle();
		track_en = 1'b1;
		base     = fwd_cnt + rev_cnt;
		guard    = 0;
		while ((fwd_cnt + rev_cnt - base) < mag && guard < (mag + 2) * 2 * STEP_DIV) begin
			next_cycle();
			guard = guard + 1;
		end
		end_burst();
	endtask

	// Hold the d-pad across a number of reloads and release inside the last one
	task automatic dpad_burst(input logic go_right, input logic fast_on, input logic by_key,
			input int reloads);
		int per;
		int base;
		int guard;
		per      = fast_on ? 9 : 4;
		exp_fwd  = fwd_cnt + (go_right ? 0 : per * reloads);
		exp_rev  = rev_cnt + (go_right ? per * reloads : 0);
		base     = fwd_cnt + rev_cnt;
		track_en = 1'b1;
		joy[5]   = fast_on;
		if (by_key)
			key_event(go_right ? arkctl_pkg::KEY_RIGHT : arkctl_pkg::KEY_LEFT, 1'b1);
		else if (go_right)
			joy[0] = 1'b1;
		else
			joy[1] = 1'b1;
		guard = 0;
		while ((fwd_cnt + rev_cnt - base) < (reloads - 1) * per + 1 &&
				guard < (reloads + 1) * 2 * POLL_TICKS) begin
			next_cycle();
			guard = guard + 1;
		end
		if (by_key)
			key_event(go_right ? arkctl_pkg::KEY_RIGHT : arkctl_pkg::KEY_LEFT, 1'b0);
		joy[1:0] = 2'b00;
		joy[5]   = 1'b0;
		guard    = 0;
		while ((fwd_cnt + rev_cnt - base) < per * reloads &&
				guard < (per + 2) * 2 * STEP_DIV) begin
			next_cycle();
			guard = guard + 1;
		end
		end_burst();
	endtask

	// New {B, A} pin pair where A edges step in direction A xor B
	task automatic enc_pins(input logic [1:0] pins);
		if (pins[0] != user_in[0])
			raw_ref = quad_step(pins[0] ^ pins[1], raw_ref);
		user_in[1:0] = pins;
		enc_own      = 1'b1;
		repeat (4) next_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int dx;
		CLK_12M = 1'b0;
		rst_n   = 1'b0;
		key     = '0;
		mouse   = '0;
		joy     = '0;
		user_in = 4'b1000; // Fire pin released
		ld_wr   = 1'b0;
		ld_index = '0;
		ld_addr = '0;
		ld_data = '0;
		kb_lvl  = '0;
		dip_ref = '0;
		raw_ref = 2'b11;
		enc_own = 1'b0;
		chk_en  = 1'b0;
		track_en  = 1'b0;
		burst_chk = 1'b0;
		spin_prev = 2'b11;
		lcg_state = 32'h2bbd_dcaf;
		fwd_cnt = 0;
		rev_cnt = 0;
		exp_fwd = 0;
		exp_rev = 0;
		errors  = 0;
		bursts  = 0;
		cycles  = 0;
		repeat (10) @(posedge CLK_12M);
		#5;
		rst_n = 1'b1;
		repeat (3) next_cycle();
		chk_en = 1'b1;

		// Keyboard make and break codes and one unknown code
		key_event(arkctl_pkg::KEY_START1, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_COIN1, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_START1, 1'b0);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_COIN1, 1'b0);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_START2, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_START2, 1'b0);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_COIN2, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_COIN2, 1'b0);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_SERVICE, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_SERVICE, 1'b0);
		repeat (4) next_cycle();
		key_event(8'h1C, 1'b1);
		repeat (4) next_cycle();
		key_event(arkctl_pkg::KEY_FIRE, 1'b1);
		repeat (4) next_cycle();

		// Direct buttons while the fire key is still held
		joy[4] = 1'b1;
		repeat (3) next_cycle();
		key_event(arkctl_pkg::KEY_FIRE, 1'b0);
		repeat (3) next_cycle();
		joy[4] = 1'b0;
		repeat (3) next_cycle();
		joy[6] = 1'b1;
		repeat (3) next_cycle();
		joy[7] = 1'b1;
		repeat (3) next_cycle();
		joy[7:6] = 2'b00;
		repeat (3) next_cycle();
		mouse.btn_left = 1'b1;
		repeat (3) next_cycle();
		mouse.btn_left = 1'b0;
		repeat (3) next_cycle();
		mouse.btn_right = 1'b1;
		repeat (3) next_cycle();
		mouse.btn_right = 1'b0;
		repeat (3) next_cycle();
		user_in[3] = 1'b0;
		repeat (3) next_cycle();
		user_in[3] = 1'b1;
		repeat (3) next_cycle();

		// Only index 254 at address 0 loads the DIP byte
		dip_write(8'd254, 8'd0, 8'hA5);
		repeat (2) next_cycle();
		dip_write(8'd253, 8'd0, 8'h3C);
		repeat (2) next_cycle();
		dip_write(8'd254, 8'd1, 8'h0F);
		repeat (2) next_cycle();
		dip_write(8'd254, 8'd0, 8'h00);
		repeat (2) next_cycle();

		// Random mouse motion
		repeat (N_BURSTS) begin
			lcg_state = lcg_next(lcg_state);
			dx = int'({24'd0, lcg_state[23:16]}) % 201 - 100;
			mouse_burst(dx);
		end

		// D-pad bursts
		dpad_burst(1'b1, 1'b0, 1'b0, 3);
		dpad_burst(1'b1, 1'b1, 1'b0, 1);
		dpad_burst(1'b0, 1'b0, 1'b1, 3);
		dpad_burst(1'b0, 1'b1, 1'b1, 1);

		// Physical encoder takes over and a mouse event hands back
		track_en = 1'b0;
		enc_pins(2'b10); // B alone only switches the source
		enc_pins(2'b11);
		enc_pins(2'b10);
		enc_pins(2'b11);
		enc_pins(2'b01);
		enc_pins(2'b00);
		enc_pins(2'b01);
		enc_pins(2'b00);
		enc_pins(2'b01);
		enc_own = 1'b0;
		lcg_state = lcg_next(lcg_state);
		mouse_burst(int'({24'd0, lcg_state[23:16]}) % 201 - 100);

		repeat (4) next_cycle();
		$display("Errors: %0d, bursts checked: %0d", errors, bursts);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the control front end testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_control_top \
	-f verilog.f \
	-o sim_control_top

./obj_dir/sim_control_top | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
	echo "run_sim: pass"
else
	echo "run_sim: fail"
	exit 1
fi

/* verilog.f */
design/arkctl_pkg.sv
design/key_decoder.sv
design/spinner_emu.sv
design/quad_encoder_halver.sv
design/cabinet_inputs.sv
design/control_top.sv
dv/tb_control_top.sv
